/* logic/bp_macros.svh */
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// word address width, byte bits [1:0] already dropped
`define BP_PC_W 30

// entries per btb bank, index is pc[7:1]
`define BP_BTB_DEPTH 128

// two-bit counters, index is pc[7:0]
`define BP_PHT_DEPTH 256

`endif

/* logic/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // branch kind as stored in the btb
    typedef enum logic [1:0] {
        br_none     = 2'd0,   // miss or invalidated entry
        br_cond     = 2'd1,   // conditional, direction from pht
        br_direct   = 2'd2,   // unconditional, fixed target
        br_indirect = 2'd3    // register jump, last seen target
    } br_type_t;

    // saturating direction counter
    // msb set means taken
    typedef enum logic [1:0] {
        strong_nt = 2'd0,
        weak_nt   = 2'd1,
        weak_t    = 2'd2,
        strong_t  = 2'd3
    } ctr_state_t;

endpackage

`default_nettype wire

/* logic/sdp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// simple dual port memory
// one clocked write port, one combinational read port
module sdp_ram #(
    parameter int ram_width = 8,
    parameter int ram_depth = 128
) (
    input  logic                         clk,
    input  logic                         we,      // write strobe
    input  logic [$clog2(ram_depth)-1:0] waddr,
    input  logic [ram_width-1:0]         wdata,
    input  logic [$clog2(ram_depth)-1:0] raddr,
    output logic [ram_width-1:0]         rdata
);

    logic [ram_width-1:0] mem [ram_depth];   // no reset on contents

    // write lands at the edge
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // read is async, so same-cycle write still shows old data
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* logic/btb_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

// one bank of the branch target buffer
// bank 0 holds even words, bank 1 odd words
module btb_bank #(
    parameter bit bank_id = 1'b0                  // word parity served by this bank
) (
    input  logic                  clk,
    input  logic                  rstn,
    // lookup side
    input  logic [`BP_PC_W-1:0]   pc,
    output bp_pkg::br_type_t      br_type,        // br_none on a miss
    output logic [`BP_PC_W-1:0]   br_target,
    // update side, single cycle strobe
    input  logic                  update,
    input  logic [`BP_PC_W-1:0]   update_pc,
    input  bp_pkg::br_type_t      update_br_type,
    input  logic [`BP_PC_W-1:0]   update_br_target
);
    import bp_pkg::*;

    localparam int idx_w = $clog2(`BP_BTB_DEPTH); // 7 index bits
    localparam int tag_w = `BP_PC_W - idx_w - 1;  // 22 tag bits above the index

    logic [`BP_PC_W-1:0]     lookup_addr;   // pc with parity forced to this bank
    logic [idx_w-1:0]        lk_idx;
    logic [tag_w-1:0]        lk_tag;
    logic [idx_w-1:0]        up_idx;
    logic [tag_w-1:0]        up_tag;
    logic                    bank_we;       // update aimed at this bank
    logic [`BP_BTB_DEPTH-1:0] valid;
    logic [tag_w-1:0]        rd_tag;
    logic [1:0]              rd_type;
    logic [`BP_PC_W-1:0]     rd_target;
    logic                    hit;

    //////////////////////////////
    // address split

    assign lookup_addr = {pc[`BP_PC_W-1:1], bank_id};
    assign lk_idx      = lookup_addr[idx_w:1];
    assign lk_tag      = lookup_addr[`BP_PC_W-1:idx_w+1];
    assign up_idx      = update_pc[idx_w:1];
    assign up_tag      = update_pc[`BP_PC_W-1:idx_w+1];
    assign bank_we     = update && (update_pc[0] == bank_id);

    // valid set by real branch types, cleared by br_none
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            valid <= '0;
        end
        else if (bank_we)
        begin
            valid[up_idx] <= (update_br_type != br_none);
        end
    end

    //////////////////////////////
    // entry fields

    sdp_ram #(.ram_width(tag_w), .ram_depth(`BP_BTB_DEPTH)) u_tag_ram (
        .clk   (clk),
        .we    (bank_we),
        .waddr (up_idx),
        .wdata (up_tag),
        .raddr (lk_idx),
        .rdata (rd_tag)
    );

    sdp_ram #(.ram_width(2), .ram_depth(`BP_BTB_DEPTH)) u_type_ram (
        .clk   (clk),
        .we    (bank_we),
        .waddr (up_idx),
        .wdata (update_br_type),
        .raddr (lk_idx),
        .rdata (rd_type)
    );

    sdp_ram #(.ram_width(`BP_PC_W), .ram_depth(`BP_BTB_DEPTH)) u_target_ram (
        .clk   (clk),
        .we    (bank_we),
        .waddr (up_idx),
        .wdata (update_br_target),
        .raddr (lk_idx),
        .rdata (rd_target)
    );

    //////////////////////////////
    // hit compare

    assign hit = valid[lk_idx] && (rd_tag == lk_tag);

    always_comb
    begin
        if (hit)
        begin
            br_type   = br_type_t'(rd_type);
            br_target = rd_target;
        end
        else
        begin
            br_type   = br_none;
            br_target = lookup_addr + `BP_PC_W'(1);   // sequential word on a miss
        end
    end

endmodule

`default_nettype wire

/* logic/pht.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

// pattern history table, two-bit counters
// two read ports for the pair, one update port
module pht (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`BP_PC_W-1:0]  pc,
    output logic                 taken0,          // even word of the pair
    output logic                 taken1,          // odd word of the pair
    input  logic                 update,
    input  logic [`BP_PC_W-1:0]  update_pc,
    input  bp_pkg::br_type_t     update_br_type,
    input  logic                 update_taken     // resolved direction
);
    import bp_pkg::*;

    localparam int idx_w = $clog2(`BP_PHT_DEPTH);   // 8 index bits

    ctr_state_t       ctr [`BP_PHT_DEPTH];
    logic [idx_w-1:0] rd_idx0;
    logic [idx_w-1:0] rd_idx1;
    logic [idx_w-1:0] up_idx;
    logic             ctr_we;

    // one step toward the resolved direction, saturating
    function automatic ctr_state_t ctr_step(input ctr_state_t cur, input logic tk);
        ctr_state_t nxt;
        nxt = cur;
        case (cur)
            strong_nt: nxt = tk ? weak_nt  : strong_nt;
            weak_nt:   nxt = tk ? weak_t   : strong_nt;
            weak_t:    nxt = tk ? strong_t : weak_nt;
            strong_t:  nxt = tk ? strong_t : weak_t;
            default:   nxt = weak_nt;
        endcase
        return nxt;
    endfunction

    assign rd_idx0 = {pc[idx_w-1:1], 1'b0};
    assign rd_idx1 = {pc[idx_w-1:1], 1'b1};
    assign up_idx  = update_pc[idx_w-1:0];
    assign ctr_we  = update && (update_br_type == br_cond);   // only cond trains

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `BP_PHT_DEPTH; i++)
            begin
                ctr[i] <= weak_nt;   // start just below taken
            end
        end
        else if (ctr_we)
        begin
            ctr[up_idx] <= ctr_step(ctr[up_idx], update_taken);
        end
    end

    assign taken0 = (ctr[rd_idx0] == weak_t) || (ctr[rd_idx0] == strong_t);
    assign taken1 = (ctr[rd_idx1] == weak_t) || (ctr[rd_idx1] == strong_t);

endmodule

`default_nettype wire

/* logic/next_pc_sel.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

// picks the first taken slot at or after pc
// falls through to the next aligned pair otherwise
module next_pc_sel (
    input  logic [`BP_PC_W-1:0]  pc,
    input  bp_pkg::br_type_t     type0,          // even bank result
    input  bp_pkg::br_type_t     type1,          // odd bank result
    input  logic [`BP_PC_W-1:0]  target0,
    input  logic [`BP_PC_W-1:0]  target1,
    input  logic                 taken0,         // pht direction, even word
    input  logic                 taken1,         // pht direction, odd word
    output logic                 pred_taken,
    output logic                 pred_slot,      // 0 even, 1 odd
    output bp_pkg::br_type_t     pred_br_type,
    output logic [`BP_PC_W-1:0]  pred_next_pc
);
    import bp_pkg::*;

    logic                consider0;     // slot 0 lies at or after pc
    logic                take0;
    logic                take1;
    logic [`BP_PC_W-1:0] fall_through;

    assign consider0 = ~pc[0];

    // unconditional always taken, cond follows its counter
    assign take0 = consider0 &&
                   ((type0 == br_direct) || (type0 == br_indirect) ||
                    ((type0 == br_cond) && taken0));
    assign take1 = (type1 == br_direct) || (type1 == br_indirect) ||
                   ((type1 == br_cond) && taken1);

    assign fall_through = {pc[`BP_PC_W-1:1], 1'b0} + `BP_PC_W'(2);   // next pair

    //////////////////////////////
    // priority, lowest slot first

    always_comb
    begin
        pred_taken   = 1'b0;
        pred_slot    = 1'b0;
        pred_br_type = br_none;
        pred_next_pc = fall_through;
        if (take0)
        begin
            pred_taken   = 1'b1;
            pred_br_type = type0;
            pred_next_pc = target0;
        end
        else if (take1)
        begin
            pred_taken   = 1'b1;
            pred_slot    = 1'b1;
            pred_br_type = type1;
            pred_next_pc = target1;
        end
        else if (consider0 && (type0 == br_cond))
        begin
            pred_br_type = br_cond;   // cond hit predicted not taken
        end
        else if (type1 == br_cond)
        begin
            pred_br_type = br_cond;
        end
    end

endmodule

`default_nettype wire

/* logic/branch_pred.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

// two-slot fetch predictor top
module branch_pred (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`BP_PC_W-1:0]  pc,               // word address of fetch
    // resolved branch from the back end
    input  logic                 update,
    input  logic [`BP_PC_W-1:0]  update_pc,
    input  bp_pkg::br_type_t     update_br_type,
    input  logic [`BP_PC_W-1:0]  update_br_target,
    input  logic                 update_taken,
    // prediction, same cycle as pc
    output logic                 pred_taken,
    output logic                 pred_slot,
    output bp_pkg::br_type_t     pred_br_type,
    output logic [`BP_PC_W-1:0]  pred_next_pc
);
    import bp_pkg::*;

    br_type_t            type0;
    br_type_t            type1;
    logic [`BP_PC_W-1:0] target0;
    logic [`BP_PC_W-1:0] target1;
    logic                taken0;
    logic                taken1;

    //////////////////////////////
    // btb banks, even then odd

    btb_bank #(.bank_id(1'b0)) u_bank0 (
        .clk(clk), .rstn(rstn), .pc(pc),
        .br_type(type0), .br_target(target0),
        .update(update), .update_pc(update_pc),
        .update_br_type(update_br_type), .update_br_target(update_br_target)
    );

    btb_bank #(.bank_id(1'b1)) u_bank1 (
        .clk(clk), .rstn(rstn), .pc(pc),
        .br_type(type1), .br_target(target1),
        .update(update), .update_pc(update_pc),
        .update_br_type(update_br_type), .update_br_target(update_br_target)
    );

    // direction counters
    pht u_pht (
        .clk(clk), .rstn(rstn), .pc(pc),
        .taken0(taken0), .taken1(taken1),
        .update(update), .update_pc(update_pc),
        .update_br_type(update_br_type), .update_taken(update_taken)
    );

    next_pc_sel u_sel (
        .pc(pc), .type0(type0), .type1(type1),
        .target0(target0), .target1(target1),
        .taken0(taken0), .taken1(taken1),
        .pred_taken(pred_taken), .pred_slot(pred_slot),
        .pred_br_type(pred_br_type), .pred_next_pc(pred_next_pc)
    );

endmodule

`default_nettype wire

/* bench/branch_pred_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

// properties on the predictor outputs and the pht counters
module branch_pred_checker (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [`BP_PC_W-1:0]  pc,
    input  logic                 pred_taken,
    input  logic                 pred_slot,
    input  bp_pkg::br_type_t     pred_br_type,
    input  logic [`BP_PC_W-1:0]  pred_next_pc,
    input  bp_pkg::ctr_state_t   ctr_even,      // counter read for slot 0
    input  bp_pkg::ctr_state_t   ctr_odd        // counter read for slot 1
);

    logic [`BP_PC_W-1:0] fall_through;

    assign fall_through = {pc[`BP_PC_W-1:1], 1'b0} + `BP_PC_W'(2);   // next aligned pair

    //////////////////////////////
    // output properties

    a_outputs_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown({pred_taken, pred_slot, pred_br_type, pred_next_pc}))
        else $error("prediction outputs carry x or z");

    // no taken slot means slot 0 and the sequential pair
    a_not_taken_falls_through: assert property (@(posedge clk) disable iff (!rstn)
        !pred_taken |-> ((pred_slot == 1'b0) && (pred_next_pc == fall_through)))
        else $error("not-taken prediction without slot 0 and fall-through pc");

    //////////////////////////////
    // counter encoding

    // every known two-bit code is a state, so only x or z leaves the set
    a_ctr_legal: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown({ctr_even, ctr_odd}))
        else $error("pht counter outside the two-bit states");

endmodule

bind branch_pred branch_pred_checker u_checker (
    .clk(clk), .rstn(rstn), .pc(pc),
    .pred_taken(pred_taken), .pred_slot(pred_slot),
    .pred_br_type(pred_br_type), .pred_next_pc(pred_next_pc),
    .ctr_even(u_pht.ctr[u_pht.rd_idx0]),
    .ctr_odd(u_pht.ctr[u_pht.rd_idx1])
);

`default_nettype wire

/* bench/branch_pred_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

// file-driven testbench for the two-slot predictor
module branch_pred_tb;
    import bp_pkg::*;

    localparam int max_tests    = 128;
    localparam int reset_cycles = 5;

    logic                clk;
    logic                rstn;
    logic [`BP_PC_W-1:0] pc;
    logic                update;
    logic [`BP_PC_W-1:0] update_pc;
    br_type_t            update_br_type;
    logic [`BP_PC_W-1:0] update_br_target;
    logic                update_taken;
    logic                pred_taken;
    logic                pred_slot;
    br_type_t            pred_br_type;
    logic [`BP_PC_W-1:0] pred_next_pc;

    logic [7:0]  test_op  [max_tests];      // u update, l lookup, x both
    logic [31:0] test_fld [max_tests][9];   // fields in file order
    int          n_tests;
    int          passes;
    int          fails;
    int          cycle_limit;
    bit          limit_ready;               // watchdog starts once tests are loaded
    int          cycles;

    branch_pred uut (
        .clk(clk), .rstn(rstn), .pc(pc),
        .update(update), .update_pc(update_pc),
        .update_br_type(update_br_type), .update_br_target(update_br_target),
        .update_taken(update_taken),
        .pred_taken(pred_taken), .pred_slot(pred_slot),
        .pred_br_type(pred_br_type), .pred_next_pc(pred_next_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    //////////////////////////////
    // test file loading

    task automatic load_tests(output bit ok);
        int          fd;
        int          code;
        int          ch;
        int          n_fld;
        logic [7:0]  op_c;
        logic [31:0] val;
        ok      = 1'b1;
        n_tests = 0;
        fd      = $fopen("bench/branch_pred_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open bench/branch_pred_tests.txt");
            ok = 1'b0;
        end
        else
        begin
            code = $fscanf(fd, " %c", op_c);
            while (ok && (code == 1))
            begin
                if (op_c == "#")
                begin
                    ch = $fgetc(fd);   // comment, drop the rest of the line
                    while ((ch != "\n") && (ch != -1))
                    begin
                        ch = $fgetc(fd);
                    end
                end
                else
                begin
                    case (op_c)
                        "u":     n_fld = 4;   // pc type target taken
                        "l":     n_fld = 5;   // pc taken slot type next
                        "x":     n_fld = 9;   // update fields then lookup fields
                        default: n_fld = 0;
                    endcase
                    if ((n_fld == 0) || (n_tests == max_tests))
                    begin
                        $display("test file line not understood at test %0d", n_tests);
                        ok = 1'b0;
                    end
                    for (int k = 0; k < n_fld; k++)
                    begin
                        code = $fscanf(fd, " %h", val);
                        if (code != 1)
                        begin
                            $display("test %0d is missing field %0d", n_tests, k);
                            ok = 1'b0;
                        end
                        test_fld[n_tests][k] = val;
                    end
                    test_op[n_tests] = op_c;
                    n_tests++;
                end
                code = $fscanf(fd, " %c", op_c);
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // drive and compare

    // one test per cycle, inputs change on the rising edge
    task automatic drive_test(input int i);
        @(posedge clk);
        update <= (test_op[i] != "l");
        if (test_op[i] != "l")
        begin
            update_pc        <= test_fld[i][0][`BP_PC_W-1:0];
            update_br_type   <= br_type_t'(test_fld[i][1][1:0]);
            update_br_target <= test_fld[i][2][`BP_PC_W-1:0];
            update_taken     <= test_fld[i][3][0];
        end
        if (test_op[i] == "l")
        begin
            pc <= test_fld[i][0][`BP_PC_W-1:0];
        end
        else if (test_op[i] == "x")
        begin
            pc <= test_fld[i][4][`BP_PC_W-1:0];   // same cycle as the update
        end
    endtask

    task automatic check_lookup(input int i, input int b);
        bit bad;
        bad = 1'b0;
        if (pred_taken !== test_fld[i][b+1][0])
        begin
            $display("error at %0t: test %0d pred_taken is %b, expected %b",
                     $time, i, pred_taken, test_fld[i][b+1][0]);
            bad = 1'b1;
        end
        if (pred_slot !== test_fld[i][b+2][0])
        begin
            $display("error at %0t: test %0d pred_slot is %b, expected %b",
                     $time, i, pred_slot, test_fld[i][b+2][0]);
            bad = 1'b1;
        end
        if (pred_br_type !== test_fld[i][b+3][1:0])
        begin
            $display("error at %0t: test %0d pred_br_type is %0d, expected %0d",
                     $time, i, pred_br_type, test_fld[i][b+3][1:0]);
            bad = 1'b1;
        end
        if (pred_next_pc !== test_fld[i][b+4][`BP_PC_W-1:0])
        begin
            $display("error at %0t: test %0d pred_next_pc is %h, expected %h",
                     $time, i, pred_next_pc, test_fld[i][b+4][`BP_PC_W-1:0]);
            bad = 1'b1;
        end
        if (bad)
        begin
            fails++;
        end
        else
        begin
            passes++;
        end
        $display("test %0d lookup pc %h %s", i, pc, bad ? "mismatch" : "ok");
    endtask

    //////////////////////////////
    // main sequence

    initial
    begin : main
        bit ok;
        rstn             = 1'b0;
        pc               = '0;
        update           = 1'b0;
        update_pc        = '0;
        update_br_type   = br_none;
        update_br_target = '0;
        update_taken     = 1'b0;
        passes           = 0;
        fails            = 0;
        load_tests(ok);
        if (ok)
        begin
            cycle_limit = 4 * n_tests + reset_cycles + 20;
            limit_ready = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            rstn <= 1'b1;
            for (int i = 0; i < n_tests; i++)
            begin
                drive_test(i);
                @(negedge clk);   // mid cycle, lookup has settled
                if (test_op[i] == "u")
                begin
                    $display("test %0d update pc %h applied", i, update_pc);
                end
                else
                begin
                    check_lookup(i, (test_op[i] == "x") ? 4 : 0);
                end
            end
            @(posedge clk);
            update <= 1'b0;   // drop a trailing strobe
        end
        else
        begin
            fails++;
        end
        $display("%0d passed, %0d failed", passes, fails);
        if (fails == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, limit follows the number of tests
    initial
    begin : watchdog
        cycles = 0;
        wait (limit_ready);
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles without finishing the tests", cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* branch_pred.f */
+incdir+logic
logic/bp_pkg.sv
logic/sdp_ram.sv
logic/btb_bank.sv
logic/pht.sv
logic/next_pc_sel.sv
logic/branch_pred.sv
bench/branch_pred_checker.sv
bench/branch_pred_tb.sv

/* bench/branch_pred_tests.txt */
# u update_pc type target taken / l pc exp_taken exp_slot exp_type exp_next_pc
# x: u fields then l fields in one cycle; hex values, type 0 none 1 cond 2 direct 3 indirect
# after reset every lookup misses
l 00000010 0 0 0 00000012
l 00000011 0 0 0 00000012
l 3ffffffe 0 0 0 00000000
# direct hit, tag alias, odd bank leaves even entry alone
u 00000020 2 00000100 0
l 00000020 1 0 2 00000100
l 00000120 0 0 0 00000122
u 00000021 3 00000200 0
l 00000020 1 0 2 00000100
l 00000021 1 1 3 00000200
l 00000121 0 0 0 00000122
# conditional counter steps
u 00000040 1 00000300 1
u 00000040 1 00000300 0
l 00000040 0 0 1 00000042
l 00000041 0 0 0 00000042
u 00000040 1 00000300 1
l 00000040 1 0 1 00000300
u 00000040 1 00000300 1
u 00000040 1 00000300 1
u 00000040 1 00000300 0
l 00000040 1 0 1 00000300
u 00000040 1 00000300 0
u 00000040 1 00000300 0
l 00000040 0 0 1 00000042
# not-taken cond in slot 0 lets slot 1 win
u 00000041 2 00000400 0
l 00000040 1 1 2 00000400
l 00000041 1 1 2 00000400
# invalidation
u 00000020 0 00000000 0
l 00000020 1 1 3 00000200
u 00000021 0 00000000 0
l 00000020 0 0 0 00000022
# same-cycle lookup sees old contents
x 00000080 2 00000500 0 00000080 0 0 0 00000082
l 00000080 1 0 2 00000500
x 00000080 0 00000000 0 00000080 1 0 2 00000500
l 00000080 0 0 0 00000082
